/* hw/riscCorePkg.sv */
`default_nettype none

package riscCorePkg;

  // ====================
  // widths and constants
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int REG_COUNT  = 32;
  // byte step from one instruction to the next
  localparam int unsigned INSN_STEP = 4;

  // major opcodes that the core executes
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] regAddr_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } aluOp_t;

  typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} storeSize_t;

  // where alu input a comes from
  typedef enum logic [1:0] {SRCA_RS1, SRCA_PC, SRCA_ZERO} srcA_t;

  // ====================
  // records passed between stages
  typedef struct packed {
    logic       valid;
    word_t      pc;
    aluOp_t     aluOp;
    srcA_t      srcA;
    logic       useImm;
    word_t      imm;
    regAddr_t   rs1;
    regAddr_t   rs2;
    regAddr_t   rd;
    logic       needRs1;
    logic       needRs2;
    logic       writesRd;
    logic       isStore;
    storeSize_t storeSize;
  } decodedInsn_t;

  typedef struct packed {
    logic       valid;
    aluOp_t     aluOp;
    word_t      opA;
    word_t      opB;
    regAddr_t   rd;
    logic       writesRd;
    logic       isStore;
    storeSize_t storeSize;
    word_t      storeData;
  } execOp_t;

  typedef struct packed {
    logic     valid;
    regAddr_t rd;
    word_t    value;
  } writeback_t;

  typedef struct packed {
    word_t      addr;
    word_t      data;
    logic [3:0] byteEn;
  } storeReq_t;

endpackage

`default_nettype wire

/* hw/fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               insnWait,
  input  wire riscCorePkg::word_t insnRespAddr,
  input  wire logic               stall,
  output riscCorePkg::word_t      insnAddr,
  output logic                    insnRead,
  output riscCorePkg::word_t      expectAddr
);
  import riscCorePkg::*;

  word_t pc;
  logic  respMatch;
  logic  respMissed;
  logic  refetch;

  // response for the next instruction in program order
  assign respMatch  = !insnWait && (insnRespAddr == expectAddr);
  // response ahead of the expected one, so that word went missing
  assign respMissed = !insnWait && (insnRespAddr > expectAddr);
  // refused by a decode stall, or lost on the bus
  assign refetch    = (respMatch && stall) || respMissed;

  assign insnAddr = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc         <= '0;
      expectAddr <= '0;
      insnRead   <= 1'b0;
    end else begin
      // read level comes up one edge after reset and stays
      insnRead <= 1'b1;
      if (refetch) begin
        pc <= expectAddr;
      end else if (insnRead && !insnWait) begin
        pc <= pc + INSN_STEP;
      end
      // decode takes the word under the same condition
      if (respMatch && !stall) begin
        expectAddr <= expectAddr + INSN_STEP;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  wire logic                        clk,
  input  wire logic                        rst_n,
  input  wire riscCorePkg::word_t          insnData,
  input  wire riscCorePkg::word_t          insnRespAddr,
  input  wire logic                        insnWait,
  input  wire riscCorePkg::word_t          expectAddr,
  input  wire logic                        stall,
  output riscCorePkg::decodedInsn_t        decoded,
  output riscCorePkg::decodedInsn_t        issue
);
  import riscCorePkg::*;

  decodedInsn_t nextInsn;
  logic         take;
  logic [6:0]   opcode;
  logic [2:0]   funct3;
  logic [6:0]   funct7;
  word_t        immI;
  word_t        immS;
  word_t        immU;

  // funct3 plus the alternate bit picks the alu operation
  function automatic aluOp_t aluFor(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // only the in-order response is taken, and never while stalled
  assign take = !insnWait && (insnRespAddr == expectAddr) && !stall;

  assign opcode = insnData[6:0];
  assign funct3 = insnData[14:12];
  assign funct7 = insnData[31:25];
  assign immI   = {{20{insnData[31]}}, insnData[31:20]};
  assign immS   = {{20{insnData[31]}}, insnData[31:25], insnData[11:7]};
  assign immU   = {insnData[31:12], 12'b0};

  always_comb begin
    nextInsn          = '0;
    nextInsn.pc       = insnRespAddr;
    nextInsn.rs1      = insnData[19:15];
    nextInsn.rs2      = insnData[24:20];
    nextInsn.rd       = insnData[11:7];
    nextInsn.aluOp    = ALU_ADD;
    nextInsn.srcA     = SRCA_RS1;
    // rd zero never counts as a write
    nextInsn.writesRd = (insnData[11:7] != '0);
    case (opcode)
      OPC_OP: begin
        // funct7 0x20 only for sub and sra
        nextInsn.valid   = (funct7 == 7'h00) ||
                           (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
        nextInsn.aluOp   = aluFor(funct3, insnData[30]);
        nextInsn.needRs1 = 1'b1;
        nextInsn.needRs2 = 1'b1;
      end
      OPC_OPIMM: begin
        // shifts carry funct7 in the immediate
        nextInsn.valid   = (funct3 == 3'b001) ? (funct7 == 7'h00) :
                           (funct3 == 3'b101) ? (funct7 == 7'h00 || funct7 == 7'h20) : 1'b1;
        // no subi, so the alternate bit counts only for srai
        nextInsn.aluOp   = aluFor(funct3, (funct3 == 3'b101) && insnData[30]);
        nextInsn.useImm  = 1'b1;
        nextInsn.imm     = immI;
        nextInsn.needRs1 = 1'b1;
      end
      OPC_LUI: begin
        nextInsn.valid  = 1'b1;
        nextInsn.srcA   = SRCA_ZERO;
        nextInsn.useImm = 1'b1;
        nextInsn.imm    = immU;
      end
      OPC_AUIPC: begin
        nextInsn.valid  = 1'b1;
        nextInsn.srcA   = SRCA_PC;
        nextInsn.useImm = 1'b1;
        nextInsn.imm    = immU;
      end
      OPC_STORE: begin
        nextInsn.valid    = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
        nextInsn.useImm   = 1'b1;
        nextInsn.imm      = immS;
        nextInsn.needRs1  = 1'b1;
        nextInsn.needRs2  = 1'b1;
        nextInsn.writesRd = 1'b0;
        nextInsn.isStore  = 1'b1;
        case (funct3)
          3'b000:  nextInsn.storeSize = SIZE_BYTE;
          3'b001:  nextInsn.storeSize = SIZE_HALF;
          default: nextInsn.storeSize = SIZE_WORD;
        endcase
      end
      default: begin
        // anything else becomes a no-op
        nextInsn.valid = 1'b0;
      end
    endcase
    // a no-op must not touch the scoreboard
    if (!nextInsn.valid) begin
      nextInsn.writesRd = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      decoded <= '0;
    end else if (!stall) begin
      if (take) begin
        decoded <= nextInsn;
      end else begin
        // bubble when nothing usable arrived
        decoded.valid <= 1'b0;
      end
    end
  end

  // held instruction goes out only when the scoreboard lets it
  always_comb begin
    issue       = decoded;
    issue.valid = decoded.valid && !stall;
  end

endmodule

`default_nettype wire

/* hw/hazardScoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardScoreboard (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire riscCorePkg::decodedInsn_t decoded,
  input  wire riscCorePkg::writeback_t   wb,
  output logic                           stall
);
  import riscCorePkg::*;

  // one bit per register with a result still in flight
  logic [REG_COUNT-1:0] busy;
  logic                 setBusy;
  logic                 rs1Busy;
  logic                 rs2Busy;
  logic                 rdBusy;

  assign rs1Busy = decoded.needRs1 && busy[decoded.rs1];
  assign rs2Busy = decoded.needRs2 && busy[decoded.rs2];
  // waiting on rd keeps writebacks to one register in order
  assign rdBusy  = decoded.writesRd && busy[decoded.rd];

  assign stall   = decoded.valid && (rs1Busy || rs2Busy || rdBusy);

  // issue of an instruction that writes rd
  assign setBusy = decoded.valid && !stall && decoded.writesRd;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      if (wb.valid) begin
        busy[wb.rd] <= 1'b0;
      end
      // later assignment, so a set beats a clear
      if (setBusy) begin
        busy[decoded.rd] <= 1'b1;
      end
      // x0 is never busy
      busy[0] <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/operandStage.sv */
`timescale 1ns/1ps
`default_nettype none

module operandStage (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire riscCorePkg::decodedInsn_t issue,
  input  wire riscCorePkg::writeback_t   wb,
  output riscCorePkg::execOp_t           op
);
  import riscCorePkg::*;

  word_t regs [REG_COUNT];
  word_t rs1Val;
  word_t rs2Val;
  word_t opA;
  word_t opB;

  // ====================
  // register file
  always_ff @(posedge clk) begin
    if (wb.valid && wb.rd != '0) begin
      regs[wb.rd] <= wb.value;
    end
  end

  // x0 reads zero, the value being written passes straight through
  assign rs1Val = (issue.rs1 == '0) ? '0 :
                  (wb.valid && wb.rd == issue.rs1) ? wb.value : regs[issue.rs1];
  assign rs2Val = (issue.rs2 == '0) ? '0 :
                  (wb.valid && wb.rd == issue.rs2) ? wb.value : regs[issue.rs2];

  // ====================
  // operand selection
  always_comb begin
    case (issue.srcA)
      SRCA_PC:   opA = issue.pc;
      SRCA_ZERO: opA = '0;
      default:   opA = rs1Val;
    endcase
    opB = issue.useImm ? issue.imm : rs2Val;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op <= '0;
    end else begin
      op.valid     <= issue.valid;
      op.aluOp     <= issue.aluOp;
      op.opA       <= opA;
      op.opB       <= opB;
      op.rd        <= issue.rd;
      op.writesRd  <= issue.writesRd;
      op.isStore   <= issue.isStore;
      op.storeSize <= issue.storeSize;
      // store data is rs2 regardless of the immediate
      op.storeData <= rs2Val;
    end
  end

endmodule

`default_nettype wire

/* hw/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire riscCorePkg::execOp_t op,
  output riscCorePkg::writeback_t   wb,
  output logic                      storeStrobe,
  output riscCorePkg::storeReq_t    store
);
  import riscCorePkg::*;

  word_t      aluResult;
  logic [4:0] shamt;
  logic [3:0] byteEn;

  // shifts use the low five bits of b
  assign shamt = op.opB[4:0];

  // ====================
  // alu
  always_comb begin
    case (op.aluOp)
      ALU_SUB:  aluResult = op.opA - op.opB;
      ALU_SLL:  aluResult = op.opA << shamt;
      ALU_SLT:  aluResult = {{(XLEN-1){1'b0}}, $signed(op.opA) < $signed(op.opB)};
      ALU_SLTU: aluResult = {{(XLEN-1){1'b0}}, op.opA < op.opB};
      ALU_XOR:  aluResult = op.opA ^ op.opB;
      ALU_SRL:  aluResult = op.opA >> shamt;
      ALU_SRA:  aluResult = word_t'($signed(op.opA) >>> shamt);
      ALU_OR:   aluResult = op.opA | op.opB;
      ALU_AND:  aluResult = op.opA & op.opB;
      default:  aluResult = op.opA + op.opB;
    endcase
  end

  // byte lanes by size, data stays unshifted
  always_comb begin
    case (op.storeSize)
      SIZE_BYTE: byteEn = 4'b0001;
      SIZE_HALF: byteEn = 4'b0011;
      SIZE_WORD: byteEn = 4'b1111;
      default:   byteEn = 4'b0000;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb          <= '0;
      storeStrobe <= 1'b0;
      store       <= '0;
    end else begin
      wb.valid     <= op.valid && op.writesRd;
      wb.rd        <= op.rd;
      wb.value     <= aluResult;
      // one-cycle pulse per store
      storeStrobe  <= op.valid && op.isStore;
      store.addr   <= op.opA + op.opB;
      store.data   <= op.storeData;
      store.byteEn <= byteEn;
    end
  end

endmodule

`default_nettype wire

/* hw/riscCore.sv */
`timescale 1ns/1ps
`default_nettype none

module riscCore (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire riscCorePkg::word_t insnData,
  input  wire riscCorePkg::word_t insnRespAddr,
  input  wire logic               insnWait,
  output riscCorePkg::word_t      insnAddr,
  output logic                    insnRead,
  output logic                    storeStrobe,
  output riscCorePkg::storeReq_t  store
);
  import riscCorePkg::*;

  word_t        expectAddr;
  logic         stall;
  decodedInsn_t decoded;
  decodedInsn_t issue;
  execOp_t      op;
  writeback_t   wb;

  // ====================
  // fetch, decode and issue control
  fetchStage fetch_i (
    .clk(clk), .rst_n(rst_n), .insnWait(insnWait), .insnRespAddr(insnRespAddr),
    .stall(stall), .insnAddr(insnAddr), .insnRead(insnRead), .expectAddr(expectAddr)
  );

  decodeStage decode_i (
    .clk(clk), .rst_n(rst_n), .insnData(insnData), .insnRespAddr(insnRespAddr),
    .insnWait(insnWait), .expectAddr(expectAddr), .stall(stall),
    .decoded(decoded), .issue(issue)
  );

  hazardScoreboard scoreboard_i (
    .clk(clk), .rst_n(rst_n), .decoded(decoded), .wb(wb), .stall(stall)
  );

  // ====================
  // operands, execute and writeback
  operandStage operand_i (
    .clk(clk), .rst_n(rst_n), .issue(issue), .wb(wb), .op(op)
  );

  executeStage execute_i (
    .clk(clk), .rst_n(rst_n), .op(op), .wb(wb),
    .storeStrobe(storeStrobe), .store(store)
  );

endmodule

`default_nettype wire

/* testbench/riscCoreProperties.sv */
`timescale 1ns/1ps
`default_nettype none

module riscCoreProperties (
  input wire logic                   clk,
  input wire logic                   rst_n,
  input wire logic                   insnRead,
  input wire logic                   insnWait,
  input wire logic                   stall,
  input wire logic                   storeStrobe,
  input wire riscCorePkg::word_t     insnAddr,
  input wire riscCorePkg::storeReq_t store
);

  // bus outputs stay quiet while reset is held
  quietInReset: assert property (@(posedge clk) !rst_n |-> (!insnRead && !storeStrobe))
    else $error("insnRead or storeStrobe high during reset");

  // only byte, half and word lanes
  legalByteEn: assert property (@(posedge clk) disable iff (!rst_n)
    storeStrobe |-> (store.byteEn == 4'b0001 || store.byteEn == 4'b0011 ||
                     store.byteEn == 4'b1111))
    else $error("illegal byteEn on a store pulse");

  // empty response slot, so the same address stays on the bus
  addrHoldOnWait: assert property (@(posedge clk) disable iff (!rst_n)
    (insnWait && !stall) |=> $stable(insnAddr))
    else $error("insnAddr moved while insnWait was high");

endmodule

bind riscCore riscCoreProperties props_i (
  .clk(clk), .rst_n(rst_n), .insnRead(insnRead), .insnWait(insnWait), .stall(stall),
  .storeStrobe(storeStrobe), .insnAddr(insnAddr), .store(store)
);

`default_nettype wire

/* testbench/riscCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module riscCoreTb;
  import riscCorePkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int BODY_LEN     = 200;
  // lui and addi per register, random body, then one sw per register
  localparam int PROG_LEN     = 2 * (REG_COUNT - 1) + BODY_LEN + REG_COUNT;
  localparam int DRAIN_CYCLES = 40;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + PROG_LEN * 20;
  // addi x0, x0, 0
  localparam word_t NOP = {12'b0, 5'b0, 3'b0, 5'b0, OPC_OPIMM};

  logic      clk;
  logic      rst_n;
  word_t     insnData = '0;
  word_t     insnRespAddr = '0;
  logic      insnWait = 1'b1;
  word_t     insnAddr;
  logic      insnRead;
  logic      storeStrobe;
  storeReq_t store;

  word_t       prog [PROG_LEN];
  word_t       model [REG_COUNT];
  storeReq_t   expectQ [$];
  int          storeCount = 0;
  word_t       sampledAddr = '0;
  logic        sampledRead = 1'b0;
  int unsigned waitDraw;

  riscCore dut_i (
    .clk(clk), .rst_n(rst_n), .insnData(insnData), .insnRespAddr(insnRespAddr),
    .insnWait(insnWait), .insnAddr(insnAddr), .insnRead(insnRead),
    .storeStrobe(storeStrobe), .store(store)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ====================
  // instruction encoders and ISA reference
  function automatic word_t encR(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1,
                                 logic [2:0] f3, regAddr_t rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic word_t encI(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3,
                                 regAddr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t encS(logic [11:0] imm, regAddr_t rs2, regAddr_t rs1,
                                 logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t encU(logic [19:0] imm, regAddr_t rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // RV32I result by funct3, alt selects sub or sra
  function automatic word_t aluRef(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // sb, sh, sw lanes
  function automatic logic [3:0] laneMask(logic [2:0] f3);
    case (f3)
      3'b000:  return 4'b0001;
      3'b001:  return 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  // half the time reuse the last result
  function automatic regAddr_t pickSrc(regAddr_t lastRd);
    int unsigned r;
    r = $urandom;
    if (r[0]) begin
      return lastRd;
    end
    return r[8:4];
  endfunction

  function automatic regAddr_t pickRd();
    int unsigned r;
    r = $urandom;
    return r[4:0];
  endfunction

  // ====================
  // program and in-order model
  task automatic genProgram();
    int unsigned r;
    int          n;
    regAddr_t    a;
    regAddr_t    b;
    regAddr_t    rd;
    regAddr_t    lastRd;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm12;
    logic [19:0] imm20;
    word_t       res;
    logic        wr;
    storeReq_t   req;
    n = 0;
    lastRd = 5'd1;
    model[0] = '0;
    // every register gets a known value first
    for (int i = 1; i < REG_COUNT; i++) begin
      r = $urandom;
      imm20 = r[31:12];
      imm12 = r[11:0];
      prog[n] = encU(imm20, regAddr_t'(i), OPC_LUI);
      prog[n + 1] = encI(imm12, regAddr_t'(i), 3'b000, regAddr_t'(i), OPC_OPIMM);
      model[i] = {imm20, 12'b0} + sext12(imm12);
      n += 2;
    end
    for (int k = 0; k < BODY_LEN; k++) begin
      r = $urandom;
      a = pickSrc(lastRd);
      b = pickSrc(lastRd);
      rd = pickRd();
      f3 = r[6:4];
      alt = r[7];
      imm12 = r[19:8];
      imm20 = r[27:8];
      wr = 1'b1;
      res = '0;
      case (r[3:0])
        4'd0, 4'd1, 4'd2, 4'd3, 4'd15: begin
          // alternate funct7 only exists for sub and sra
          alt = alt && (f3 == 3'b000 || f3 == 3'b101);
          prog[n] = encR({1'b0, alt, 5'b0}, b, a, f3, rd, OPC_OP);
          res = aluRef(f3, alt, model[a], model[b]);
        end
        4'd4, 4'd5, 4'd6, 4'd7: begin
          alt = alt && (f3 == 3'b101);
          // shift immediates carry funct7 and a 5 bit amount
          if (f3 == 3'b001 || f3 == 3'b101) begin
            imm12 = {1'b0, alt, 5'b0, imm12[4:0]};
          end
          prog[n] = encI(imm12, a, f3, rd, OPC_OPIMM);
          res = aluRef(f3, alt, model[a], sext12(imm12));
        end
        4'd8: begin
          prog[n] = encU(imm20, rd, OPC_LUI);
          res = {imm20, 12'b0};
        end
        4'd9: begin
          prog[n] = encU(imm20, rd, OPC_AUIPC);
          res = word_t'(n * 4) + {imm20, 12'b0};
        end
        4'd10, 4'd11, 4'd12: begin
          f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
          prog[n] = encS(imm12, b, a, f3);
          req.addr = model[a] + sext12(imm12);
          req.data = model[b];
          req.byteEn = laneMask(f3);
          expectQ.push_back(req);
          wr = 1'b0;
        end
        4'd13: begin
          // lw encoding, dropped from this core
          prog[n] = encI(imm12, a, 3'b010, rd, 7'b0000011);
          wr = 1'b0;
        end
        default: begin
          // jal encoding, also a no-op here
          prog[n] = encU(imm20, rd, 7'b1101111);
          wr = 1'b0;
        end
      endcase
      if (wr && rd != '0) begin
        model[rd] = res;
        lastRd = rd;
      end
      n++;
    end
    // dump every register, x0 included
    for (int i = 0; i < REG_COUNT; i++) begin
      prog[n] = encS(12'(i * 4), regAddr_t'(i), 5'd0, 3'b010);
      req.addr = word_t'(i * 4);
      req.data = model[i];
      req.byteEn = 4'b1111;
      expectQ.push_back(req);
      n++;
    end
  endtask

  // ====================
  // instruction memory
  function automatic word_t memWord(word_t addr);
    int idx;
    idx = int'(addr >> 2);
    if (addr[1:0] == 2'b00 && addr < word_t'(PROG_LEN * 4)) begin
      return prog[idx];
    end
    // past the program the core only sees no-ops
    return NOP;
  endfunction

  always @(posedge clk) begin
    sampledAddr <= insnAddr;
    sampledRead <= insnRead;
  end

  // answer the previous edge's request, or leave the slot empty
  always @(negedge clk) begin
    waitDraw = $urandom;
    if (sampledRead && waitDraw[1:0] != 2'b00) begin
      insnWait     <= 1'b0;
      insnRespAddr <= sampledAddr;
      insnData     <= memWord(sampledAddr);
    end else begin
      insnWait <= 1'b1;
    end
  end

  // ====================
  // checks
  task automatic abortRun();
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkBit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED: %s expected %b actual %b", name, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkWord(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
      abortRun();
    end
  endtask

  // fields shown as addr, data and byteEn
  task automatic checkStore(string name, storeReq_t expected, storeReq_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED: %s expected %h %h %b actual %h %h %b", name,
               expected.addr, expected.data, expected.byteEn,
               actual.addr, actual.data, actual.byteEn);
      abortRun();
    end
  endtask

  task automatic checkCount(string name, int expected, int actual);
    if (actual != expected) begin
      $display("CHECK FAILED: %s expected %0d actual %0d", name, expected, actual);
      abortRun();
    end
  endtask

  // each pulse must be the next store in program order
  always @(negedge clk) begin
    if (storeStrobe) begin
      // pulses beyond the model's stores only raise the final count
      if (storeCount < expectQ.size()) begin
        checkStore($sformatf("store %0d", storeCount), expectQ[storeCount], store);
      end
      storeCount <= storeCount + 1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired with %0d of %0d stores seen", storeCount, expectQ.size());
    abortRun();
  end

  // ====================
  // main sequence
  initial begin
    void'($urandom(32'h769c));
    rst_n = 1'b0;
    genProgram();
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      checkBit("insnRead during reset", 1'b0, insnRead);
    end
    rst_n = 1'b1;
    // read level comes up at the first edge after release
    @(negedge clk);
    checkBit("insnRead after release", 1'b1, insnRead);
    checkWord("first fetch address", '0, insnAddr);
    while (storeCount < expectQ.size()) begin
      @(negedge clk);
    end
    // nothing more may appear once the no-ops run
    repeat (DRAIN_CYCLES) @(negedge clk);
    checkCount("store count", expectQ.size(), storeCount);
    if (storeCount == expectQ.size()) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Result: FAILED");
      $fatal(1, "store count mismatch");
    end
  end

endmodule

`default_nettype wire

/* build.f */
hw/riscCorePkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/hazardScoreboard.sv
hw/operandStage.sv
hw/executeStage.sv
hw/riscCore.sv
testbench/riscCoreProperties.sv
testbench/riscCoreTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

# build the testbench with the bound properties
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module riscCoreTb -f build.f -o riscCoreSim

# the log decides the result, so a failing run must not stop the script here
./obj_dir/riscCoreSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
